//--- wb_dsp_defs.svh
`ifndef WB_DSP_DEFS_SVH
`define WB_DSP_DEFS_SVH

`define WB_DW 32
`define WB_AW 32

// host register map
`define REG_CONTROL 32'h00
`define REG_STATUS  32'h04
`define REG_EQ0     32'h08
`define REG_EQ1     32'h0c
`define REG_EQ2     32'h10
`define REG_EQ3     32'h14

`define CONTROL_REG_SELECT         3:0
`define CONTROL_REG_BEGIN_EQUATION 4
`define CONTROL_REG_STOP_EQUATION  5

`define STATUS_REG_ACTIVE 0
`define STATUS_REG_COUNT  15:8   // descriptors done, wraps

// descriptor layout in system memory
`define EQUATION_CONTROL_OFFSET      32'h00
`define EQUATION_STATUS_OFFSET       32'h04
`define EQUATION_NEXT_ADDRESS_OFFSET 32'h08
`define EQUATION_RESULT_OFFSET       32'h0c
`define EQUATION_OPERAND_OFFSET      32'h10

`define CONTROL_EQUATION_OPCODE 3:0
`define CONTROL_EQUATION_COUNT  15:8
`define STATUS_EQUATION_DONE    0

`endif

//--- wb_dsp_bus_pkg.sv
package wb_dsp_bus_pkg;

   typedef enum logic {
      BUS_IDLE,
      BUS_CYCLE
   } bus_state_t;

   typedef enum logic [2:0] {
      REG_IDX_CONTROL,
      REG_IDX_STATUS,
      REG_IDX_EQ0,
      REG_IDX_EQ1,
      REG_IDX_EQ2,
      REG_IDX_EQ3,
      REG_IDX_NONE   // unmapped address
   } reg_index_t;

endpackage

//--- wb_dsp_eq_pkg.sv
package wb_dsp_eq_pkg;

   typedef enum logic [3:0] {
      ALG_IDLE,
      ALG_FETCH_CONTROL,
      ALG_FETCH_CONTROL_DONE,
      ALG_FETCH_STATUS,
      ALG_FETCH_STATUS_DONE,
      ALG_FETCH_NEXT,
      ALG_FETCH_NEXT_DONE,
      ALG_RUN_EQUATION,
      ALG_WRITE_STATUS,
      ALG_WRITE_STATUS_DONE,
      ALG_ERROR
   } alg_state_t;

   typedef enum logic [2:0] {
      ENG_IDLE,
      ENG_READ,
      ENG_READ_WAIT,
      ENG_WRITE,
      ENG_WRITE_WAIT,
      ENG_DONE
   } eng_state_t;

   typedef enum logic [3:0] {
      EQ_SUM = 4'd0,
      EQ_XOR = 4'd1
   } eq_opcode_t;

endpackage

//--- wb_dsp_slave_regs.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module wb_dsp_slave_regs (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic [`WB_AW-1:0] host_adr,
   input  logic [`WB_DW-1:0] host_dat_i,
   input  logic [3:0]        host_sel,
   input  logic              host_we,
   input  logic              host_cyc,
   input  logic              host_stb,
   output logic [`WB_DW-1:0] host_dat_o,
   output logic              host_ack,
   input  logic [`WB_DW-1:0] status_reg,
   output logic [`WB_DW-1:0] control_reg,
   output logic [`WB_DW-1:0] equation0_address_reg,
   output logic [`WB_DW-1:0] equation1_address_reg,
   output logic [`WB_DW-1:0] equation2_address_reg,
   output logic [`WB_DW-1:0] equation3_address_reg
);

   wb_dsp_bus_pkg::reg_index_t reg_idx;
   logic access;
   logic wr_en;

   assign access = host_cyc & host_stb & ~host_ack; // no second ack for the same cycle
   assign wr_en  = access & host_we & (host_sel == 4'hf);

   always_comb begin
      case (host_adr)
         `REG_CONTROL: reg_idx = wb_dsp_bus_pkg::REG_IDX_CONTROL;
         `REG_STATUS:  reg_idx = wb_dsp_bus_pkg::REG_IDX_STATUS;
         `REG_EQ0:     reg_idx = wb_dsp_bus_pkg::REG_IDX_EQ0;
         `REG_EQ1:     reg_idx = wb_dsp_bus_pkg::REG_IDX_EQ1;
         `REG_EQ2:     reg_idx = wb_dsp_bus_pkg::REG_IDX_EQ2;
         `REG_EQ3:     reg_idx = wb_dsp_bus_pkg::REG_IDX_EQ3;
         default:      reg_idx = wb_dsp_bus_pkg::REG_IDX_NONE;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         host_ack              <= 1'b0;
         control_reg           <= '0;
         equation0_address_reg <= '0;
         equation1_address_reg <= '0;
         equation2_address_reg <= '0;
         equation3_address_reg <= '0;
      end else begin
         host_ack <= access;
         if (wr_en && reg_idx == wb_dsp_bus_pkg::REG_IDX_CONTROL)
            control_reg <= host_dat_i;
         else
            control_reg[`CONTROL_REG_BEGIN_EQUATION] <= 1'b0; // begin is a one-shot
         if (wr_en) begin
            case (reg_idx)
               wb_dsp_bus_pkg::REG_IDX_EQ0: equation0_address_reg <= host_dat_i;
               wb_dsp_bus_pkg::REG_IDX_EQ1: equation1_address_reg <= host_dat_i;
               wb_dsp_bus_pkg::REG_IDX_EQ2: equation2_address_reg <= host_dat_i;
               wb_dsp_bus_pkg::REG_IDX_EQ3: equation3_address_reg <= host_dat_i;
               default: ;   // status is read only
            endcase
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      case (reg_idx)
         wb_dsp_bus_pkg::REG_IDX_CONTROL: host_dat_o <= control_reg;
         wb_dsp_bus_pkg::REG_IDX_STATUS:  host_dat_o <= status_reg;
         wb_dsp_bus_pkg::REG_IDX_EQ0:     host_dat_o <= equation0_address_reg;
         wb_dsp_bus_pkg::REG_IDX_EQ1:     host_dat_o <= equation1_address_reg;
         wb_dsp_bus_pkg::REG_IDX_EQ2:     host_dat_o <= equation2_address_reg;
         wb_dsp_bus_pkg::REG_IDX_EQ3:     host_dat_o <= equation3_address_reg;
         default:                         host_dat_o <= '0;
      endcase
   end

   a_single_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      host_ack |=> !host_ack);

endmodule

//--- wb_dsp_algorithm_sm.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module wb_dsp_algorithm_sm (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic [3:0]        begin_equation,
   input  logic [`WB_DW-1:0] control_reg,
   input  logic [`WB_DW-1:0] equation0_address_reg,
   input  logic [`WB_DW-1:0] equation1_address_reg,
   input  logic [`WB_DW-1:0] equation2_address_reg,
   input  logic [`WB_DW-1:0] equation3_address_reg,
   output logic [`WB_DW-1:0] status_reg,
   output logic              alg_start,
   output logic              alg_write,
   output logic [`WB_AW-1:0] alg_address,
   output logic [`WB_DW-1:0] alg_data_wr,
   output logic [3:0]        alg_selection,
   input  logic              active,
   input  logic [`WB_DW-1:0] alg_data_rd,
   output logic [7:0]        equation_enable,
   output logic [`WB_DW-1:0] equation_control,
   output logic [`WB_AW-1:0] base_address,
   input  logic              equation_done
);

   wb_dsp_eq_pkg::alg_state_t state;
   logic              begin_q;
   logic              manual_start;
   logic [3:0]        src;
   logic [`WB_AW-1:0] sel_base;
   logic              xfer_done;
   logic [`WB_DW-1:0] equation_status;
   logic [`WB_AW-1:0] equation_next;
   logic [7:0]        desc_count;

   assign manual_start = control_reg[`CONTROL_REG_BEGIN_EQUATION] & ~begin_q &
                         (state == wb_dsp_eq_pkg::ALG_IDLE);
   assign src = begin_equation | (manual_start ? control_reg[`CONTROL_REG_SELECT] : 4'h0);
   // master still busy while our own start pulse is in flight
   assign xfer_done = ~alg_start & ~active;
   assign alg_selection = 4'hf;

   always_comb begin
      if (src[0])      sel_base = equation0_address_reg;
      else if (src[1]) sel_base = equation1_address_reg;
      else if (src[2]) sel_base = equation2_address_reg;
      else if (src[3]) sel_base = equation3_address_reg;
      else             sel_base = '0;
   end

   always_comb begin
      status_reg = '0;
      status_reg[`STATUS_REG_ACTIVE] = (state != wb_dsp_eq_pkg::ALG_IDLE);
      status_reg[`STATUS_REG_COUNT]  = desc_count;
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state           <= wb_dsp_eq_pkg::ALG_IDLE;
         begin_q         <= 1'b0;
         alg_start       <= 1'b0;
         equation_enable <= '0;
         desc_count      <= '0;
      end else begin
         begin_q   <= control_reg[`CONTROL_REG_BEGIN_EQUATION];
         alg_start <= 1'b0;
         case (state)
            wb_dsp_eq_pkg::ALG_IDLE: begin
               if (manual_start || |begin_equation) begin
                  base_address <= sel_base;
                  state <= (sel_base == '0) ? wb_dsp_eq_pkg::ALG_ERROR :
                                              wb_dsp_eq_pkg::ALG_FETCH_CONTROL;
               end
            end
            wb_dsp_eq_pkg::ALG_FETCH_CONTROL: begin
               alg_start   <= 1'b1;
               alg_write   <= 1'b0;
               alg_address <= base_address + `EQUATION_CONTROL_OFFSET;
               state       <= wb_dsp_eq_pkg::ALG_FETCH_CONTROL_DONE;
            end
            wb_dsp_eq_pkg::ALG_FETCH_CONTROL_DONE: begin
               if (xfer_done) begin
                  equation_control <= alg_data_rd;
                  if (alg_data_rd[`CONTROL_EQUATION_COUNT] == 8'd0)
                     state <= wb_dsp_eq_pkg::ALG_ERROR;
                  else
                     state <= wb_dsp_eq_pkg::ALG_FETCH_STATUS;
               end
            end
            wb_dsp_eq_pkg::ALG_FETCH_STATUS: begin
               alg_start   <= 1'b1;
               alg_address <= base_address + `EQUATION_STATUS_OFFSET;
               state       <= wb_dsp_eq_pkg::ALG_FETCH_STATUS_DONE;
            end
            wb_dsp_eq_pkg::ALG_FETCH_STATUS_DONE: begin
               if (xfer_done) begin
                  equation_status <= alg_data_rd;
                  state <= wb_dsp_eq_pkg::ALG_FETCH_NEXT;
               end
            end
            wb_dsp_eq_pkg::ALG_FETCH_NEXT: begin
               alg_start   <= 1'b1;
               alg_address <= base_address + `EQUATION_NEXT_ADDRESS_OFFSET;
               state       <= wb_dsp_eq_pkg::ALG_FETCH_NEXT_DONE;
            end
            wb_dsp_eq_pkg::ALG_FETCH_NEXT_DONE: begin
               if (xfer_done) begin
                  equation_next   <= alg_data_rd;
                  equation_enable <= 8'h01 << equation_control[2:0]; // one-hot opcode
                  state <= wb_dsp_eq_pkg::ALG_RUN_EQUATION;
               end
            end
            wb_dsp_eq_pkg::ALG_RUN_EQUATION: begin
               if (equation_done) begin
                  equation_enable <= '0;  // hand the master back
                  state <= wb_dsp_eq_pkg::ALG_WRITE_STATUS;
               end
            end
            wb_dsp_eq_pkg::ALG_WRITE_STATUS: begin
               alg_start   <= 1'b1;
               alg_write   <= 1'b1;
               alg_address <= base_address + `EQUATION_STATUS_OFFSET;
               alg_data_wr <= equation_status | (32'h1 << `STATUS_EQUATION_DONE);
               state       <= wb_dsp_eq_pkg::ALG_WRITE_STATUS_DONE;
            end
            wb_dsp_eq_pkg::ALG_WRITE_STATUS_DONE: begin
               if (xfer_done) begin
                  desc_count <= desc_count + 8'd1;
                  if (equation_next != '0 && !control_reg[`CONTROL_REG_STOP_EQUATION]) begin
                     base_address <= equation_next;  // follow the chain
                     state <= wb_dsp_eq_pkg::ALG_FETCH_CONTROL;
                  end else begin
                     state <= wb_dsp_eq_pkg::ALG_IDLE;
                  end
               end
            end
            default: state <= wb_dsp_eq_pkg::ALG_IDLE;  // error included
         endcase
      end
   end

   a_start_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      alg_start |=> !alg_start);
   a_start_idle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      alg_start |-> !active);

endmodule

//--- wb_dsp_bus_master.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module wb_dsp_bus_master (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic              alg_start,
   input  logic              alg_write,
   input  logic [`WB_AW-1:0] alg_address,
   input  logic [`WB_DW-1:0] alg_data_wr,
   input  logic [3:0]        alg_selection,
   input  logic              eng_start,
   input  logic              eng_write,
   input  logic [`WB_AW-1:0] eng_address,
   input  logic [`WB_DW-1:0] eng_data_wr,
   input  logic [7:0]        equation_enable,
   output logic              active,
   output logic [`WB_DW-1:0] data_rd,
   output logic [`WB_AW-1:0] mem_adr,
   output logic [`WB_DW-1:0] mem_dat_o,
   input  logic [`WB_DW-1:0] mem_dat_i,
   output logic              mem_we,
   output logic [3:0]        mem_sel,
   output logic              mem_cyc,
   output logic              mem_stb,
   input  logic              mem_ack
);

   wb_dsp_bus_pkg::bus_state_t state;
   logic eng_owns;
   logic start;

   assign eng_owns = |equation_enable;
   assign start    = eng_owns ? eng_start : alg_start;
   assign active   = (state == wb_dsp_bus_pkg::BUS_CYCLE);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state   <= wb_dsp_bus_pkg::BUS_IDLE;
         mem_cyc <= 1'b0;
         mem_stb <= 1'b0;
      end else begin
         case (state)
            wb_dsp_bus_pkg::BUS_IDLE: begin
               if (start) begin
                  mem_adr   <= eng_owns ? eng_address : alg_address;
                  mem_dat_o <= eng_owns ? eng_data_wr : alg_data_wr;
                  mem_we    <= eng_owns ? eng_write   : alg_write;
                  mem_sel   <= eng_owns ? 4'hf        : alg_selection;
                  mem_cyc   <= 1'b1;
                  mem_stb   <= 1'b1;
                  state     <= wb_dsp_bus_pkg::BUS_CYCLE;
               end
            end
            default: begin
               if (mem_ack) begin
                  data_rd <= mem_dat_i;  // don't care on writes
                  mem_cyc <= 1'b0;
                  mem_stb <= 1'b0;
                  state   <= wb_dsp_bus_pkg::BUS_IDLE;
               end
            end
         endcase
      end
   end

   a_stb_in_cyc: assert property (@(posedge wb_clk) disable iff (wb_rst)
      mem_stb |-> mem_cyc);

endmodule

//--- wb_dsp_equation_engine.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module wb_dsp_equation_engine (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic [7:0]        equation_enable,
   input  logic [`WB_DW-1:0] equation_control,
   input  logic [`WB_AW-1:0] base_address,
   input  logic              active,
   input  logic [`WB_DW-1:0] data_rd,
   output logic              eng_start,
   output logic              eng_write,
   output logic [`WB_AW-1:0] eng_address,
   output logic [`WB_DW-1:0] eng_data_wr,
   output logic              equation_done
);

   wb_dsp_eq_pkg::eng_state_t state;
   wb_dsp_eq_pkg::eq_opcode_t opcode;
   logic [7:0]        count;
   logic [7:0]        idx;
   logic [`WB_DW-1:0] acc;
   logic              xfer_done;

   assign opcode = wb_dsp_eq_pkg::eq_opcode_t'(equation_control[`CONTROL_EQUATION_OPCODE]);
   assign count  = equation_control[`CONTROL_EQUATION_COUNT];
   assign xfer_done = ~eng_start & ~active;
   assign equation_done = (state == wb_dsp_eq_pkg::ENG_DONE);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state     <= wb_dsp_eq_pkg::ENG_IDLE;
         eng_start <= 1'b0;
      end else begin
         eng_start <= 1'b0;
         case (state)
            wb_dsp_eq_pkg::ENG_IDLE: begin
               if (|equation_enable) begin
                  idx   <= '0;
                  acc   <= '0;
                  state <= wb_dsp_eq_pkg::ENG_READ;
               end
            end
            wb_dsp_eq_pkg::ENG_READ: begin
               eng_start   <= 1'b1;
               eng_write   <= 1'b0;
               eng_address <= base_address + `EQUATION_OPERAND_OFFSET + {22'd0, idx, 2'b00};
               state       <= wb_dsp_eq_pkg::ENG_READ_WAIT;
            end
            wb_dsp_eq_pkg::ENG_READ_WAIT: begin
               if (xfer_done) begin
                  case (opcode)
                     wb_dsp_eq_pkg::EQ_XOR: acc <= acc ^ data_rd;
                     default:               acc <= acc + data_rd;
                  endcase
                  idx <= idx + 8'd1;
                  if (idx + 8'd1 == count)
                     state <= wb_dsp_eq_pkg::ENG_WRITE;
                  else
                     state <= wb_dsp_eq_pkg::ENG_READ;
               end
            end
            wb_dsp_eq_pkg::ENG_WRITE: begin
               eng_start   <= 1'b1;
               eng_write   <= 1'b1;
               eng_address <= base_address + `EQUATION_RESULT_OFFSET;
               eng_data_wr <= acc;
               state       <= wb_dsp_eq_pkg::ENG_WRITE_WAIT;
            end
            wb_dsp_eq_pkg::ENG_WRITE_WAIT: begin
               if (xfer_done)
                  state <= wb_dsp_eq_pkg::ENG_DONE;
            end
            default: state <= wb_dsp_eq_pkg::ENG_IDLE; // done lasts one cycle
         endcase
      end
   end

endmodule

//--- wb_dsp_top.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module wb_dsp_top (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic [3:0]        begin_equation,
   input  logic [`WB_AW-1:0] host_adr,
   input  logic [`WB_DW-1:0] host_dat_i,
   output logic [`WB_DW-1:0] host_dat_o,
   input  logic              host_we,
   input  logic [3:0]        host_sel,
   input  logic              host_cyc,
   input  logic              host_stb,
   output logic              host_ack,
   output logic [`WB_AW-1:0] mem_adr,
   output logic [`WB_DW-1:0] mem_dat_o,
   input  logic [`WB_DW-1:0] mem_dat_i,
   output logic              mem_we,
   output logic [3:0]        mem_sel,
   output logic              mem_cyc,
   output logic              mem_stb,
   input  logic              mem_ack
);

   logic [`WB_DW-1:0] control_reg, status_reg;
   logic [`WB_DW-1:0] equation0_address_reg, equation1_address_reg;
   logic [`WB_DW-1:0] equation2_address_reg, equation3_address_reg;
   logic              alg_start, alg_write, eng_start, eng_write;
   logic [`WB_AW-1:0] alg_address, eng_address, base_address;
   logic [`WB_DW-1:0] alg_data_wr, eng_data_wr, data_rd, equation_control;
   logic [3:0]        alg_selection;
   logic              active, equation_done;
   logic [7:0]        equation_enable;

   wb_dsp_slave_regs slave (
      .wb_clk, .wb_rst, .host_adr, .host_dat_i, .host_sel, .host_we, .host_cyc,
      .host_stb, .host_dat_o, .host_ack, .status_reg, .control_reg,
      .equation0_address_reg, .equation1_address_reg,
      .equation2_address_reg, .equation3_address_reg
   );

   wb_dsp_algorithm_sm alg (
      .wb_clk, .wb_rst, .begin_equation, .control_reg,
      .equation0_address_reg, .equation1_address_reg,
      .equation2_address_reg, .equation3_address_reg, .status_reg,
      .alg_start, .alg_write, .alg_address, .alg_data_wr, .alg_selection,
      .active, .alg_data_rd(data_rd), .equation_enable, .equation_control,
      .base_address, .equation_done
   );

   wb_dsp_bus_master master (
      .wb_clk, .wb_rst, .alg_start, .alg_write, .alg_address, .alg_data_wr,
      .alg_selection, .eng_start, .eng_write, .eng_address, .eng_data_wr,
      .equation_enable, .active, .data_rd, .mem_adr, .mem_dat_o, .mem_dat_i,
      .mem_we, .mem_sel, .mem_cyc, .mem_stb, .mem_ack
   );

   wb_dsp_equation_engine engine (
      .wb_clk, .wb_rst, .equation_enable, .equation_control, .base_address,
      .active, .data_rd, .eng_start, .eng_write, .eng_address, .eng_data_wr,
      .equation_done
   );

endmodule

//--- tb_wb_dsp_mem.sv
`timescale 1ns/1ps

module tb_wb_dsp_mem (
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic [31:0] adr,
   input  logic [31:0] wr_data,
   output logic [31:0] rd_data,
   input  logic        we,
   input  logic [3:0]  sel,
   input  logic        cyc,
   input  logic        stb,
   output logic        ack
);

   logic [31:0] words [0:1023];
   logic [31:0] rd_q      = 32'h0;
   logic        ack_q     = 1'b0;
   logic        pending   = 1'b0;
   logic [1:0]  wait_left = 2'd0;

   assign rd_data = rd_q;
   assign ack     = ack_q;

   initial begin
      for (int i = 0; i < 1024; i++)
         words[i] = 32'ha5a5_0000 | 32'(i);  // every word tells its own index
   end

   always @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q   <= 1'b0;
         pending <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         if (cyc && stb && !ack_q) begin
            if (!pending) begin
               pending   <= 1'b1;
               wait_left <= 2'($urandom_range(3, 0)); // wait states for this access
            end else if (wait_left != 2'd0) begin
               wait_left <= wait_left - 2'd1;
            end else begin
               ack_q   <= 1'b1;
               pending <= 1'b0;
               if (we && sel == 4'hf)
                  words[adr[11:2]] = wr_data;
               rd_q <= words[adr[11:2]];
            end
         end
      end
   end

endmodule

//--- tb_wb_dsp.sv
`timescale 1ns/1ps
`include "wb_dsp_defs.svh"

module tb_wb_dsp;

   logic        wb_clk;
   logic        wb_rst;
   logic [3:0]  begin_equation;
   logic [31:0] host_adr;
   logic [31:0] host_dat_i;
   logic [31:0] host_dat_o;
   logic        host_we;
   logic [3:0]  host_sel;
   logic        host_cyc;
   logic        host_stb;
   logic        host_ack;
   logic [31:0] mem_adr;
   logic [31:0] mem_dat_o;
   logic [31:0] mem_dat_i;
   logic        mem_we;
   logic [3:0]  mem_sel;
   logic        mem_cyc;
   logic        mem_stb;
   logic        mem_ack;

   logic [31:0] shadow [0:1023];  // what memory should hold before the DUT touches it
   logic [31:0] exp_addr[$];
   logic [31:0] exp_val[$];
   string       exp_name[$];
   string       current_test;
   logic [7:0]  exp_count;
   logic        compare_req;
   int          errors;
   int          checks;
   int          ack_total = 0;

   wb_dsp_top dut (
      .wb_clk, .wb_rst, .begin_equation, .host_adr, .host_dat_i, .host_dat_o,
      .host_we, .host_sel, .host_cyc, .host_stb, .host_ack, .mem_adr, .mem_dat_o,
      .mem_dat_i, .mem_we, .mem_sel, .mem_cyc, .mem_stb, .mem_ack
   );

   tb_wb_dsp_mem mem (
      .wb_clk, .wb_rst, .adr(mem_adr), .wr_data(mem_dat_o), .rd_data(mem_dat_i),
      .we(mem_we), .sel(mem_sel), .cyc(mem_cyc), .stb(mem_stb), .ack(mem_ack)
   );

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      if (mem_ack) ack_total <= ack_total + 1;

   function automatic logic [31:0] ref_equation(input logic [3:0] opcode,
                                                input logic [31:0] base, input int count);
      logic [31:0] acc;
      logic [31:0] addr;
      acc = 32'h0;
      for (int i = 0; i < count; i++) begin
         addr = base + `EQUATION_OPERAND_OFFSET + 32'(i) * 32'd4;
         if (opcode == wb_dsp_eq_pkg::EQ_XOR)
            acc = acc ^ shadow[addr[11:2]];
         else
            acc = acc + shadow[addr[11:2]];
      end
      return acc;
   endfunction

   task automatic abort_run(input string why);
      errors++;
      $display("ERROR: %s: timed out, %s", current_test, why);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Simulation FAILED");
      $finish;
   endtask

   task automatic host_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
      int n;
      @(posedge wb_clk);
      #1;
      host_adr   = adr;
      host_dat_i = wdata;
      host_we    = we;
      host_sel   = 4'hf;
      host_cyc   = 1'b1;
      host_stb   = 1'b1;
      n = 0;
      while (!host_ack) begin
         if (n == 5000) abort_run("no ack from the register slave");
         @(posedge wb_clk);
         #1;
         n++;
      end
      rdata    = host_dat_o;
      host_cyc = 1'b0;
      host_stb = 1'b0;
      host_we  = 1'b0;
   endtask

   task automatic host_write(input logic [31:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      host_access(1'b1, adr, data, unused);
   endtask

   task automatic host_read(input logic [31:0] adr, output logic [31:0] data);
      host_access(1'b0, adr, 32'h0, data);
   endtask

   task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
      mem.words[addr[11:2]] = data;
      shadow[addr[11:2]]    = data;
   endtask

   task automatic build_desc(input logic [31:0] base, input logic [3:0] opcode,
                             input logic [7:0] count, input logic [31:0] next);
      store_word(base + `EQUATION_CONTROL_OFFSET, {16'h0, count, 4'h0, opcode});
      store_word(base + `EQUATION_STATUS_OFFSET, 32'h0000_5a00); // these bits must survive
      store_word(base + `EQUATION_NEXT_ADDRESS_OFFSET, next);
      store_word(base + `EQUATION_RESULT_OFFSET, 32'hdead_0000 | base);
      for (int i = 0; i < int'(count); i++)
         store_word(base + `EQUATION_OPERAND_OFFSET + 32'(i) * 32'd4, $urandom());
   endtask

   task automatic expect_word(input string what, input logic [31:0] addr,
                              input logic [31:0] value);
      exp_name.push_back({current_test, " ", what});
      exp_addr.push_back(addr);
      exp_val.push_back(value);
   endtask

   task automatic expect_done(input logic [31:0] base);
      logic [31:0] ctrl;
      logic [31:0] status_addr;
      ctrl        = shadow[base[11:2]];
      status_addr = base + `EQUATION_STATUS_OFFSET;
      expect_word("result", base + `EQUATION_RESULT_OFFSET,
                  ref_equation(ctrl[`CONTROL_EQUATION_OPCODE], base,
                               int'(ctrl[`CONTROL_EQUATION_COUNT])));
      expect_word("status", status_addr, shadow[status_addr[11:2]] | 32'h1);
      exp_count = exp_count + 8'd1;
   endtask

   task automatic expect_untouched(input logic [31:0] base);
      logic [31:0] result_addr;
      logic [31:0] status_addr;
      result_addr = base + `EQUATION_RESULT_OFFSET;
      status_addr = base + `EQUATION_STATUS_OFFSET;
      expect_word("untouched result", result_addr, shadow[result_addr[11:2]]);
      expect_word("untouched status", status_addr, shadow[status_addr[11:2]]);
   endtask

   task automatic pulse_pins(input logic [3:0] pins);
      @(posedge wb_clk);
      #1;
      begin_equation = pins;
      @(posedge wb_clk);
      #1;
      begin_equation = 4'h0;
   endtask

   // done once memory has been touched and the block reads idle again
   task automatic wait_chain(input int acks_before);
      logic [31:0] status;
      int n;
      n      = 0;
      status = 32'h1;
      while (ack_total == acks_before || status[`STATUS_REG_ACTIVE]) begin
         if (n == 5000) abort_run("descriptor chain did not finish");
         host_read(`REG_STATUS, status);
         n++;
      end
   endtask

   task automatic run_compare();
      int n;
      compare_req = 1'b1;
      n = 0;
      while (compare_req) begin
         if (n == 5000) abort_run("compare process did not finish");
         @(posedge wb_clk);
         #1;
         n++;
      end
   endtask

   task automatic compare_chain();
      logic [31:0] addr;
      logic [31:0] expected;
      logic [31:0] actual;
      logic [31:0] status;
      string       name;
      while (exp_addr.size() > 0) begin
         addr     = exp_addr.pop_front();
         expected = exp_val.pop_front();
         name     = exp_name.pop_front();
         actual   = mem.words[addr[11:2]];
         checks++;
         if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         end
      end
      host_read(`REG_STATUS, status);
      checks += 2;
      if (status[`STATUS_REG_COUNT] !== exp_count) begin
         errors++;
         $display("FAILED %s status count: expected %h, actual %h",
                  current_test, exp_count, status[`STATUS_REG_COUNT]);
      end
      if (status[`STATUS_REG_ACTIVE] !== 1'b0) begin
         errors++;
         $display("FAILED %s status active: expected 0, actual %b",
                  current_test, status[`STATUS_REG_ACTIVE]);
      end
   endtask

   always begin
      @(posedge wb_clk);
      if (compare_req) begin
         compare_chain();
         compare_req = 1'b0;
      end
   end

   initial begin
      int acks;
      logic [31:0] rd;
      void'($urandom(32'hdf13_53b0));
      wb_rst         = 1'b1;
      begin_equation = 4'h0;
      host_adr       = 32'h0;
      host_dat_i     = 32'h0;
      host_we        = 1'b0;
      host_sel       = 4'h0;
      host_cyc       = 1'b0;
      host_stb       = 1'b0;
      compare_req    = 1'b0;
      exp_count      = 8'd0;
      errors         = 0;
      checks         = 0;
      current_test   = "reset";
      repeat (10) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      current_test = "sum_by_pin";
      build_desc(32'h100, wb_dsp_eq_pkg::EQ_SUM, 8'd8, 32'h0);
      host_write(`REG_EQ2, 32'h100);
      expect_done(32'h100);
      acks = ack_total;
      pulse_pins(4'b0100);
      wait_chain(acks);
      run_compare();

      current_test = "xor_by_control";
      build_desc(32'h200, wb_dsp_eq_pkg::EQ_XOR, 8'd10, 32'h0);
      host_write(`REG_EQ1, 32'h200);
      expect_done(32'h200);
      acks = ack_total;
      host_write(`REG_CONTROL, 32'h12);  // begin with select 1
      host_write(`REG_CONTROL, 32'h12);  // lands while busy
      host_read(`REG_STATUS, rd);
      checks++;
      if (rd[`STATUS_REG_ACTIVE] !== 1'b1) begin
         errors++;
         $display("FAILED %s busy at second begin: expected 1, actual %b",
                  current_test, rd[`STATUS_REG_ACTIVE]);
      end
      wait_chain(acks);
      run_compare();

      current_test = "chain_of_three";
      build_desc(32'h300, wb_dsp_eq_pkg::EQ_SUM, 8'd4, 32'h380);
      build_desc(32'h380, wb_dsp_eq_pkg::EQ_XOR, 8'd6, 32'h400);
      build_desc(32'h400, wb_dsp_eq_pkg::EQ_SUM, 8'd12, 32'h0);
      host_write(`REG_EQ3, 32'h300);
      expect_done(32'h300);
      expect_done(32'h380);
      expect_done(32'h400);
      acks = ack_total;
      pulse_pins(4'b1000);
      wait_chain(acks);
      run_compare();

      current_test = "stop_bit";
      build_desc(32'h500, wb_dsp_eq_pkg::EQ_XOR, 8'd3, 32'h580);
      build_desc(32'h580, wb_dsp_eq_pkg::EQ_SUM, 8'd5, 32'h0);
      host_write(`REG_EQ0, 32'h500);
      host_write(`REG_CONTROL, 32'h20);
      expect_done(32'h500);
      expect_untouched(32'h580);
      acks = ack_total;
      pulse_pins(4'b0001);
      wait_chain(acks);
      run_compare();
      host_write(`REG_CONTROL, 32'h0);

      current_test = "two_pins";
      build_desc(32'h600, wb_dsp_eq_pkg::EQ_SUM, 8'd7, 32'h0);
      build_desc(32'h680, wb_dsp_eq_pkg::EQ_XOR, 8'd2, 32'h0);
      host_write(`REG_EQ1, 32'h600);
      host_write(`REG_EQ3, 32'h680);
      expect_done(32'h600);
      expect_untouched(32'h680);
      acks = ack_total;
      pulse_pins(4'b1010);  // lowest pin wins
      wait_chain(acks);
      run_compare();

      current_test = "zero_count";
      build_desc(32'h700, wb_dsp_eq_pkg::EQ_SUM, 8'd0, 32'h0);
      host_write(`REG_EQ2, 32'h700);
      expect_untouched(32'h700);
      acks = ack_total;
      pulse_pins(4'b0100);
      wait_chain(acks);
      run_compare();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- wb_dsp_top.f
+incdir+.
wb_dsp_bus_pkg.sv
wb_dsp_eq_pkg.sv
wb_dsp_slave_regs.sv
wb_dsp_algorithm_sm.sv
wb_dsp_bus_master.sv
wb_dsp_equation_engine.sv
wb_dsp_top.sv
tb_wb_dsp_mem.sv
tb_wb_dsp.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the wb_dsp testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_wb_dsp \
   -f wb_dsp_top.f -o sim_wb_dsp > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_wb_dsp > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
exit 0
